// File: logic/pipe_settings.svh
//--------------------------------------------------------------------
// Fixed RV32 configuration of the pipeline
// Changing PIPE_XLEN alone is not supported, the decoder assumes 32
//--------------------------------------------------------------------

`ifndef PIPE_SETTINGS_SVH
`define PIPE_SETTINGS_SVH

// Data, address and instruction word width
`define PIPE_XLEN           32

// Register file
`define PIPE_RF_ADDR_W      5
`define PIPE_RF_NUM         32

// First fetch address after reset
`define PIPE_RST_VECTOR     32'h0000_0200

`endif

// File: logic/pipe_pkg.sv
//--------------------------------------------------------------------
// Common types of the pipeline
// Memory response encoding follows the core's memory interface
//--------------------------------------------------------------------

`include "pipe_settings.svh"

package pipe_pkg;

//--------------------------------------------------------------------
// Vector types
//--------------------------------------------------------------------
typedef logic [`PIPE_XLEN-1:0]      xlen_t;     // Data, PC and instruction word
typedef logic [`PIPE_RF_ADDR_W-1:0] rf_addr_t;  // Register index

//--------------------------------------------------------------------
// Instruction memory response
//--------------------------------------------------------------------
typedef enum logic [1:0] {
    RESP_IDLE = 2'b00,                  // No response this cycle
    RESP_OK   = 2'b01,                  // Read data valid
    RESP_ERR  = 2'b10                   // Access fault
} mem_resp_e;

//--------------------------------------------------------------------
// ALU operation
//--------------------------------------------------------------------
typedef enum logic [2:0] {
    ALU_ADD      = 3'd0,
    ALU_SUB      = 3'd1,
    ALU_XOR      = 3'd2,
    ALU_OR       = 3'd3,
    ALU_AND      = 3'd4,
    ALU_PASS_IMM = 3'd5                 // LUI result is the immediate
} alu_op_e;

endpackage : pipe_pkg

// File: logic/pipe_ifu.sv
//--------------------------------------------------------------------
// Sequential fetch only, the address advances by 4 per word
// One request outstanding, the response must come after the ack cycle
//--------------------------------------------------------------------

`timescale 1ns/1ps

`include "pipe_settings.svh"

module pipe_ifu (
    input  logic                i_clk,
    input  logic                i_rst_n,

    // Instruction memory
    output logic                o_imem_req,
    output pipe_pkg::xlen_t     o_imem_addr,
    input  logic                i_imem_req_ack,
    input  pipe_pkg::xlen_t     i_imem_rdata,
    input  pipe_pkg::mem_resp_e i_imem_resp,

    // To decode
    output logic                o_ifu_vd,
    output pipe_pkg::xlen_t     o_ifu_instr,
    output logic                o_ifu_err,
    output pipe_pkg::xlen_t     o_ifu_pc,
    input  logic                i_idu_rdy
);

import pipe_pkg::*;

xlen_t  fetch_pc;                       // Address of the next word
logic   resp_pend;                      // Request acked, waiting for data
logic   resp_vd;
logic   buf_vd;
logic   buf_take;
logic   issue;
xlen_t  buf_instr;
logic   buf_err;
xlen_t  buf_pc;

assign resp_vd  = resp_pend & (i_imem_resp != RESP_IDLE);
assign buf_take = buf_vd & i_idu_rdy;

// New request only when the buffer is free by the time data returns
assign issue    = ~o_imem_req & ~resp_pend & (~buf_vd | buf_take);

//--------------------------------------------------------------------
// Request and buffer control
//--------------------------------------------------------------------
always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (~i_rst_n) begin
        o_imem_req <= 1'b0;
        resp_pend  <= 1'b0;
        buf_vd     <= 1'b0;
        fetch_pc   <= `PIPE_RST_VECTOR;
    end else begin
        if (issue) begin
            o_imem_req <= 1'b1;
        end else if (o_imem_req & i_imem_req_ack) begin
            o_imem_req <= 1'b0;
        end
        if (o_imem_req & i_imem_req_ack) begin
            resp_pend <= 1'b1;
        end else if (resp_vd) begin
            resp_pend <= 1'b0;
        end
        if (resp_vd) begin
            buf_vd   <= 1'b1;
            fetch_pc <= fetch_pc + xlen_t'(4);  // Address stays put until data is back
        end else if (buf_take) begin
            buf_vd   <= 1'b0;
        end
    end
end

// Returned word, fault flag and its PC
always_ff @(posedge i_clk) begin
    if (resp_vd) begin
        buf_instr <= i_imem_rdata;
        buf_err   <= (i_imem_resp == RESP_ERR);
        buf_pc    <= fetch_pc;
    end
end

assign o_imem_addr = fetch_pc;
assign o_ifu_vd    = buf_vd;
assign o_ifu_instr = buf_instr;
assign o_ifu_err   = buf_err;
assign o_ifu_pc    = buf_pc;

endmodule : pipe_ifu

// File: logic/pipe_idu.sv
//--------------------------------------------------------------------
// Decodes LUI, ADDI/XORI/ORI/ANDI and ADD/SUB/XOR/OR/AND only
// Anything else, or a faulted fetch, becomes an exception command
//--------------------------------------------------------------------

`timescale 1ns/1ps

module pipe_idu (
    input  logic                i_clk,
    input  logic                i_rst_n,

    // From fetch
    input  logic                i_ifu_vd,
    input  pipe_pkg::xlen_t     i_ifu_instr,
    input  logic                i_ifu_err,
    input  pipe_pkg::xlen_t     i_ifu_pc,
    output logic                o_idu_rdy,

    // To execute
    output logic                o_idu_vd,
    output pipe_pkg::alu_op_e   o_alu_op,
    output pipe_pkg::rf_addr_t  o_rs1,
    output pipe_pkg::rf_addr_t  o_rs2,
    output pipe_pkg::rf_addr_t  o_rd,
    output pipe_pkg::xlen_t     o_imm,
    output logic                o_use_imm,
    output logic                o_wr_en,
    output logic                o_exc,
    output pipe_pkg::xlen_t     o_pc,
    input  logic                i_exu_rdy
);

import pipe_pkg::*;

localparam logic [6:0] OPC_LUI    = 7'b0110111;
localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
localparam logic [6:0] OPC_OP     = 7'b0110011;
localparam logic [2:0] F3_ADD     = 3'b000;     // Also SUB
localparam logic [2:0] F3_XOR     = 3'b100;
localparam logic [2:0] F3_OR      = 3'b110;
localparam logic [2:0] F3_AND     = 3'b111;
localparam logic [6:0] F7_BASE    = 7'b0000000;
localparam logic [6:0] F7_ALT     = 7'b0100000; // SUB

logic [6:0] opcode;
logic [2:0] funct3;
logic [6:0] funct7;
alu_op_e    dec_op;
xlen_t      dec_imm;
logic       dec_use_imm;
logic       dec_ill;
logic       dec_exc;
logic       accept;

assign opcode = i_ifu_instr[6:0];
assign funct3 = i_ifu_instr[14:12];
assign funct7 = i_ifu_instr[31:25];

//--------------------------------------------------------------------
// Decoder
//--------------------------------------------------------------------
always_comb begin
    dec_op      = ALU_ADD;
    dec_imm     = {{20{i_ifu_instr[31]}}, i_ifu_instr[31:20]};  // I-type
    dec_use_imm = 1'b0;
    dec_ill     = 1'b0;
    case (opcode)
        OPC_LUI: begin
            dec_op      = ALU_PASS_IMM;
            dec_imm     = {i_ifu_instr[31:12], 12'h000};       // U-type
            dec_use_imm = 1'b1;
        end
        OPC_OP_IMM: begin
            dec_use_imm = 1'b1;
            case (funct3)
                F3_ADD:  dec_op  = ALU_ADD;
                F3_XOR:  dec_op  = ALU_XOR;
                F3_OR:   dec_op  = ALU_OR;
                F3_AND:  dec_op  = ALU_AND;
                default: dec_ill = 1'b1;
            endcase
        end
        OPC_OP: begin
            case ({funct7, funct3})
                {F7_BASE, F3_ADD}: dec_op  = ALU_ADD;
                {F7_ALT,  F3_ADD}: dec_op  = ALU_SUB;
                {F7_BASE, F3_XOR}: dec_op  = ALU_XOR;
                {F7_BASE, F3_OR}:  dec_op  = ALU_OR;
                {F7_BASE, F3_AND}: dec_op  = ALU_AND;
                default:           dec_ill = 1'b1;
            endcase
        end
        default: dec_ill = 1'b1;
    endcase
end

assign dec_exc   = dec_ill | i_ifu_err;
assign o_idu_rdy = ~o_idu_vd | i_exu_rdy;       // Empty or being drained
assign accept    = i_ifu_vd & o_idu_rdy;

//--------------------------------------------------------------------
// Command register
//--------------------------------------------------------------------
always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (~i_rst_n) begin
        o_idu_vd <= 1'b0;
    end else if (o_idu_rdy) begin
        o_idu_vd <= i_ifu_vd;
    end
end

always_ff @(posedge i_clk) begin
    if (accept) begin
        o_alu_op  <= dec_op;
        o_rs1     <= i_ifu_instr[19:15];
        o_rs2     <= i_ifu_instr[24:20];
        o_rd      <= i_ifu_instr[11:7];
        o_imm     <= dec_imm;
        o_use_imm <= dec_use_imm;
        o_wr_en   <= ~dec_exc;                  // No write for any exception
        o_exc     <= dec_exc;
        o_pc      <= i_ifu_pc;
    end
end

endmodule : pipe_idu

// File: logic/pipe_exu.sv
//--------------------------------------------------------------------
// Single cycle execute, writeback and retire on acceptance
// Exceptions retire with rd 0 and data 0 and leave the registers alone
//--------------------------------------------------------------------

`timescale 1ns/1ps

module pipe_exu (
    input  logic                i_clk,
    input  logic                i_rst_n,

    // From decode
    input  logic                i_idu_vd,
    input  pipe_pkg::alu_op_e   i_alu_op,
    input  pipe_pkg::rf_addr_t  i_rs1,
    input  pipe_pkg::rf_addr_t  i_rs2,
    input  pipe_pkg::rf_addr_t  i_rd,
    input  pipe_pkg::xlen_t     i_imm,
    input  logic                i_use_imm,
    input  logic                i_wr_en,
    input  logic                i_exc,
    input  pipe_pkg::xlen_t     i_pc,
    output logic                o_exu_rdy,

    // Register file
    output pipe_pkg::rf_addr_t  o_rf_rs1_addr,
    output pipe_pkg::rf_addr_t  o_rf_rs2_addr,
    input  pipe_pkg::xlen_t     i_rf_rs1_data,
    input  pipe_pkg::xlen_t     i_rf_rs2_data,
    output logic                o_rf_w_req,
    output pipe_pkg::rf_addr_t  o_rf_rd_addr,
    output pipe_pkg::xlen_t     o_rf_rd_data,

    // Retire port
    output logic                o_retire_valid,
    output pipe_pkg::xlen_t     o_retire_pc,
    output pipe_pkg::rf_addr_t  o_retire_rd,
    output pipe_pkg::xlen_t     o_retire_data,
    output logic                o_retire_exc,
    input  logic                i_retire_ready
);

import pipe_pkg::*;

xlen_t  op_b;
xlen_t  alu_res;
logic   accept;

assign o_exu_rdy     = ~o_retire_valid | i_retire_ready;
assign accept        = i_idu_vd & o_exu_rdy;
assign o_rf_rs1_addr = i_rs1;
assign o_rf_rs2_addr = i_rs2;
assign op_b          = i_use_imm ? i_imm : i_rf_rs2_data;

//--------------------------------------------------------------------
// Integer ALU
//--------------------------------------------------------------------
always_comb begin
    case (i_alu_op)
        ALU_ADD:      alu_res = i_rf_rs1_data + op_b;
        ALU_SUB:      alu_res = i_rf_rs1_data - op_b;
        ALU_XOR:      alu_res = i_rf_rs1_data ^ op_b;
        ALU_OR:       alu_res = i_rf_rs1_data | op_b;
        ALU_AND:      alu_res = i_rf_rs1_data & op_b;
        ALU_PASS_IMM: alu_res = i_imm;
        default:      alu_res = i_rf_rs1_data + op_b;
    endcase
end

// Write lands at the acceptance edge, next command reads it back
assign o_rf_w_req   = accept & i_wr_en;
assign o_rf_rd_addr = i_rd;
assign o_rf_rd_data = alu_res;

//--------------------------------------------------------------------
// Retire register
//--------------------------------------------------------------------
always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (~i_rst_n) begin
        o_retire_valid <= 1'b0;
    end else if (o_exu_rdy) begin
        o_retire_valid <= i_idu_vd;
    end
end

always_ff @(posedge i_clk) begin
    if (accept) begin
        o_retire_pc   <= i_pc;
        o_retire_rd   <= i_exc ? rf_addr_t'(0) : i_rd;
        o_retire_data <= i_exc ? xlen_t'(0) : alu_res;
        o_retire_exc  <= i_exc;
    end
end

endmodule : pipe_exu

// File: logic/pipe_mprf.sv
//--------------------------------------------------------------------
// Two combinational read ports, one write port
// x0 reads as zero and drops writes
//--------------------------------------------------------------------

`timescale 1ns/1ps

`include "pipe_settings.svh"

module pipe_mprf (
    input  logic                i_clk,
    input  logic                i_rst_n,
    input  pipe_pkg::rf_addr_t  i_rs1_addr,
    input  pipe_pkg::rf_addr_t  i_rs2_addr,
    output pipe_pkg::xlen_t     o_rs1_data,
    output pipe_pkg::xlen_t     o_rs2_data,
    input  logic                i_w_req,
    input  pipe_pkg::rf_addr_t  i_rd_addr,
    input  pipe_pkg::xlen_t     i_rd_data
);

import pipe_pkg::*;

xlen_t regs [1:`PIPE_RF_NUM-1];        // No storage for x0

always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (~i_rst_n) begin
        for (int i = 1; i < `PIPE_RF_NUM; i++) begin
            regs[i] <= '0;
        end
    end else if (i_w_req && (i_rd_addr != '0)) begin
        regs[i_rd_addr] <= i_rd_data;
    end
end

assign o_rs1_data = (i_rs1_addr == '0) ? '0 : regs[i_rs1_addr];
assign o_rs2_data = (i_rs2_addr == '0) ? '0 : regs[i_rs2_addr];

endmodule : pipe_mprf

// File: logic/pipe_top.sv
//--------------------------------------------------------------------
// Fetch, decode, execute and register file of the integer pipeline
// Up to three instructions in flight, retire latency varies
//--------------------------------------------------------------------

`timescale 1ns/1ps

module pipe_top (
    input  logic                i_clk,
    input  logic                i_rst_n,

    // Instruction memory
    output logic                o_imem_req,
    output pipe_pkg::xlen_t     o_imem_addr,
    input  logic                i_imem_req_ack,
    input  pipe_pkg::xlen_t     i_imem_rdata,
    input  pipe_pkg::mem_resp_e i_imem_resp,

    // Retire port
    output logic                o_retire_valid,
    output pipe_pkg::xlen_t     o_retire_pc,
    output pipe_pkg::rf_addr_t  o_retire_rd,
    output pipe_pkg::xlen_t     o_retire_data,
    output logic                o_retire_exc,
    input  logic                i_retire_ready
);

import pipe_pkg::*;

//--------------------------------------------------------------------
// Stage links
//--------------------------------------------------------------------
logic       ifu_vd;                     // IFU -> IDU
xlen_t      ifu_instr;
logic       ifu_err;
xlen_t      ifu_pc;
logic       idu_rdy;
logic       idu_vd;                     // IDU -> EXU
alu_op_e    alu_op;
rf_addr_t   rs1;
rf_addr_t   rs2;
rf_addr_t   rd;
xlen_t      imm;
logic       use_imm;
logic       wr_en;
logic       exc;
xlen_t      pc;
logic       exu_rdy;
rf_addr_t   rf_rs1_addr;                // EXU <-> MPRF
rf_addr_t   rf_rs2_addr;
xlen_t      rf_rs1_data;
xlen_t      rf_rs2_data;
logic       rf_w_req;
rf_addr_t   rf_rd_addr;
xlen_t      rf_rd_data;

pipe_ifu pipe_ifu_i (
    .i_clk          (i_clk),            .i_rst_n        (i_rst_n),
    .o_imem_req     (o_imem_req),       .o_imem_addr    (o_imem_addr),
    .i_imem_req_ack (i_imem_req_ack),   .i_imem_rdata   (i_imem_rdata),
    .i_imem_resp    (i_imem_resp),
    .o_ifu_vd       (ifu_vd),           .o_ifu_instr    (ifu_instr),
    .o_ifu_err      (ifu_err),          .o_ifu_pc       (ifu_pc),
    .i_idu_rdy      (idu_rdy)
);

pipe_idu pipe_idu_i (
    .i_clk          (i_clk),            .i_rst_n        (i_rst_n),
    .i_ifu_vd       (ifu_vd),           .i_ifu_instr    (ifu_instr),
    .i_ifu_err      (ifu_err),          .i_ifu_pc       (ifu_pc),
    .o_idu_rdy      (idu_rdy),          .o_idu_vd       (idu_vd),
    .o_alu_op       (alu_op),           .o_rs1          (rs1),
    .o_rs2          (rs2),              .o_rd           (rd),
    .o_imm          (imm),              .o_use_imm      (use_imm),
    .o_wr_en        (wr_en),            .o_exc          (exc),
    .o_pc           (pc),               .i_exu_rdy      (exu_rdy)
);

pipe_exu pipe_exu_i (
    .i_clk          (i_clk),            .i_rst_n        (i_rst_n),
    .i_idu_vd       (idu_vd),           .i_alu_op       (alu_op),
    .i_rs1          (rs1),              .i_rs2          (rs2),
    .i_rd           (rd),               .i_imm          (imm),
    .i_use_imm      (use_imm),          .i_wr_en        (wr_en),
    .i_exc          (exc),              .i_pc           (pc),
    .o_exu_rdy      (exu_rdy),
    .o_rf_rs1_addr  (rf_rs1_addr),      .o_rf_rs2_addr  (rf_rs2_addr),
    .i_rf_rs1_data  (rf_rs1_data),      .i_rf_rs2_data  (rf_rs2_data),
    .o_rf_w_req     (rf_w_req),         .o_rf_rd_addr   (rf_rd_addr),
    .o_rf_rd_data   (rf_rd_data),
    .o_retire_valid (o_retire_valid),   .o_retire_pc    (o_retire_pc),
    .o_retire_rd    (o_retire_rd),      .o_retire_data  (o_retire_data),
    .o_retire_exc   (o_retire_exc),     .i_retire_ready (i_retire_ready)
);

pipe_mprf pipe_mprf_i (
    .i_clk          (i_clk),            .i_rst_n        (i_rst_n),
    .i_rs1_addr     (rf_rs1_addr),      .i_rs2_addr     (rf_rs2_addr),
    .o_rs1_data     (rf_rs1_data),      .o_rs2_data     (rf_rs2_data),
    .i_w_req        (rf_w_req),         .i_rd_addr      (rf_rd_addr),
    .i_rd_data      (rf_rd_data)
);

endmodule : pipe_top

// File: tb/pipe_checker.sv
//--------------------------------------------------------------------
// Retire port monitor, one table entry per retire handshake
// Expected PC is the reset vector plus 4 per entry
//--------------------------------------------------------------------

`timescale 1ns/1ps

`include "pipe_settings.svh"

module pipe_checker #(
    parameter int N_ENTRIES = 1
) (
    input  logic                i_clk,
    input  logic                i_rst_n,
    input  logic                i_retire_valid,
    input  pipe_pkg::xlen_t     i_retire_pc,
    input  pipe_pkg::rf_addr_t  i_retire_rd,
    input  pipe_pkg::xlen_t     i_retire_data,
    input  logic                i_retire_exc,
    input  logic                i_retire_ready,
    input  pipe_pkg::rf_addr_t  i_exp_rd   [N_ENTRIES],
    input  pipe_pkg::xlen_t     i_exp_data [N_ENTRIES],
    input  logic                i_exp_exc  [N_ENTRIES],
    output logic                o_done,
    output int                  o_mismatch_cnt,
    output int                  o_other_cnt
);

import pipe_pkg::*;

localparam int RETIRE_TIMEOUT = 60;     // Cycles allowed between two retires
localparam int RST_TIMEOUT    = 20;

task automatic compare_value(input string name, input xlen_t got, input xlen_t exp);
    if (got !== exp) begin
        $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
        o_mismatch_cnt++;
    end
endtask

// Sampled at the falling edge, a handshake seen here completes at the next rise
initial begin : watch_retire
    int    idx;
    int    wait_cnt;
    logic  stop;
    xlen_t exp_pc;
    o_done         = 1'b0;
    o_mismatch_cnt = 0;
    o_other_cnt    = 0;
    idx            = 0;
    stop           = 1'b0;
    wait_cnt       = 0;
    while (i_rst_n !== 1'b1 && wait_cnt < RST_TIMEOUT) begin
        @(negedge i_clk);
        wait_cnt++;
    end
    if (i_rst_n !== 1'b1) begin
        $display("ERROR at %0t: reset was never released", $time);
        o_other_cnt++;
        stop = 1'b1;
    end
    while (!stop && idx < N_ENTRIES) begin
        wait_cnt = 0;
        @(negedge i_clk);
        while (!(i_retire_valid === 1'b1 && i_retire_ready === 1'b1)
               && wait_cnt < RETIRE_TIMEOUT) begin
            @(negedge i_clk);
            wait_cnt++;
        end
        if (i_retire_valid === 1'b1 && i_retire_ready === 1'b1) begin
            exp_pc = `PIPE_RST_VECTOR + xlen_t'(4 * idx);
            compare_value("o_retire_pc", i_retire_pc, exp_pc);
            compare_value("o_retire_rd", xlen_t'(i_retire_rd), xlen_t'(i_exp_rd[idx]));
            compare_value("o_retire_data", i_retire_data, i_exp_data[idx]);
            compare_value("o_retire_exc", xlen_t'(i_retire_exc), xlen_t'(i_exp_exc[idx]));
            idx++;
        end else begin
            $display("ERROR at %0t: instruction %0d did not retire within %0d cycles",
                     $time, idx, RETIRE_TIMEOUT);
            o_other_cnt++;
            stop = 1'b1;
        end
    end
    o_done = 1'b1;
end

endmodule : pipe_checker

// File: tb/tb_pipe_top.sv
//--------------------------------------------------------------------
// Testbench of the integer pipeline, the program table feeds the memory
// Words past the end of the table are fetched as NOPs and not checked
//--------------------------------------------------------------------

`timescale 1ns/1ps

`include "pipe_settings.svh"

module tb_pipe_top;

import pipe_pkg::*;

localparam int    N_ENTRIES   = 20;
localparam int    REQ_TIMEOUT = 50;             // Cycles without a fetch request
localparam int    RUN_TIMEOUT = 3000;
localparam int    RST_TIMEOUT = 20;
localparam xlen_t NOP         = 32'h0000_0013;  // ADDI x0, x0, 0

logic       clk;
logic       rst_n;
logic       imem_req;
xlen_t      imem_addr;
logic       imem_req_ack;
xlen_t      imem_rdata;
mem_resp_e  imem_resp;
logic       retire_valid;
xlen_t      retire_pc;
rf_addr_t   retire_rd;
xlen_t      retire_data;
logic       retire_exc;
logic       retire_ready;

xlen_t      prog_instr [N_ENTRIES];
logic       prog_err   [N_ENTRIES];         // Answer with RESP_ERR
rf_addr_t   exp_rd     [N_ENTRIES];
xlen_t      exp_data   [N_ENTRIES];
logic       exp_exc    [N_ENTRIES];
int         n_loaded;

int         seed = 32'h714fd3a5;
int         mem_errors;
logic       chk_done;
int         mismatch_cnt;
int         other_cnt;

pipe_top pipe_top_i (
    .i_clk          (clk),              .i_rst_n        (rst_n),
    .o_imem_req     (imem_req),         .o_imem_addr    (imem_addr),
    .i_imem_req_ack (imem_req_ack),     .i_imem_rdata   (imem_rdata),
    .i_imem_resp    (imem_resp),
    .o_retire_valid (retire_valid),     .o_retire_pc    (retire_pc),
    .o_retire_rd    (retire_rd),        .o_retire_data  (retire_data),
    .o_retire_exc   (retire_exc),       .i_retire_ready (retire_ready)
);

pipe_checker #(.N_ENTRIES(N_ENTRIES)) pipe_checker_i (
    .i_clk          (clk),              .i_rst_n        (rst_n),
    .i_retire_valid (retire_valid),     .i_retire_pc    (retire_pc),
    .i_retire_rd    (retire_rd),        .i_retire_data  (retire_data),
    .i_retire_exc   (retire_exc),       .i_retire_ready (retire_ready),
    .i_exp_rd       (exp_rd),           .i_exp_data     (exp_data),
    .i_exp_exc      (exp_exc),          .o_done         (chk_done),
    .o_mismatch_cnt (mismatch_cnt),     .o_other_cnt    (other_cnt)
);

task automatic add_entry(input xlen_t instr, input logic err, input rf_addr_t rd,
                         input xlen_t data, input logic exc);
    prog_instr[n_loaded] = instr;
    prog_err[n_loaded]   = err;
    exp_rd[n_loaded]     = rd;
    exp_data[n_loaded]   = data;
    exp_exc[n_loaded]    = exc;
    n_loaded++;
endtask

//--------------------------------------------------------------------
// Program table
//--------------------------------------------------------------------
initial begin
    n_loaded = 0;
    // instruction word, fetch error, expected rd, expected data, expected exception
    add_entry(32'h123450B7, 1'b0, 5'd1,  32'h1234_5000, 1'b0);   // LUI  x1, 0x12345
    add_entry(32'h67808113, 1'b0, 5'd2,  32'h1234_5678, 1'b0);   // ADDI x2, x1, 0x678
    add_entry(32'hFFF10193, 1'b0, 5'd3,  32'h1234_5677, 1'b0);   // ADDI x3, x2, -1
    add_entry(32'hFFF1C213, 1'b0, 5'd4,  32'hEDCB_A988, 1'b0);   // XORI x4, x3, -1
    add_entry(32'h00F26293, 1'b0, 5'd5,  32'hEDCB_A98F, 1'b0);   // ORI  x5, x4, 0xF
    add_entry(32'h7F02F313, 1'b0, 5'd6,  32'h0000_0180, 1'b0);   // ANDI x6, x5, 0x7F0
    add_entry(32'hFF027393, 1'b0, 5'd7,  32'hEDCB_A980, 1'b0);   // ANDI x7, x4, -16
    add_entry(32'h00638433, 1'b0, 5'd8,  32'hEDCB_AB00, 1'b0);   // ADD  x8, x7, x6
    add_entry(32'h402404B3, 1'b0, 5'd9,  32'hDB97_5488, 1'b0);   // SUB  x9, x8, x2
    add_entry(32'h0034C533, 1'b0, 5'd10, 32'hC9A3_02FF, 1'b0);   // XOR  x10, x9, x3
    add_entry(32'h006565B3, 1'b0, 5'd11, 32'hC9A3_03FF, 1'b0);   // OR   x11, x10, x6
    add_entry(32'h0055F633, 1'b0, 5'd12, 32'hC983_018F, 1'b0);   // AND  x12, x11, x5
    add_entry(32'h00508013, 1'b0, 5'd0,  32'h1234_5005, 1'b0);   // ADDI x0, x1, 5
    add_entry(32'h002006B3, 1'b0, 5'd13, 32'h1234_5678, 1'b0);   // ADD  x13, x0, x2
    add_entry(32'h00112023, 1'b0, 5'd0,  32'h0000_0000, 1'b1);   // SW is illegal here
    add_entry(32'h05500693, 1'b1, 5'd0,  32'h0000_0000, 1'b1);   // Faulted fetch
    add_entry(32'h4010C6B3, 1'b0, 5'd0,  32'h0000_0000, 1'b1);   // Bad funct7/funct3
    add_entry(32'h00068713, 1'b0, 5'd14, 32'h1234_5678, 1'b0);   // ADDI x14, x13, 0
    add_entry(32'h80000793, 1'b0, 5'd15, 32'hFFFF_F800, 1'b0);   // ADDI x15, x0, -2048
    add_entry(32'h40E78833, 1'b0, 5'd16, 32'hEDCB_A188, 1'b0);   // SUB  x16, x15, x14
end

initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
end

initial begin
    rst_n = 1'b0;
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
end

// Retire back-pressure
initial begin
    retire_ready = 1'b1;
    forever begin
        @(posedge clk);
        retire_ready <= ($unsigned($random(seed)) % 4) != 0;  // Low about one cycle in four
    end
end

//--------------------------------------------------------------------
// Instruction memory model
//--------------------------------------------------------------------
initial begin : imem_model
    int   wait_cnt;
    int   delay;
    int   word_idx;
    logic stop;
    imem_req_ack = 1'b0;
    imem_rdata   = '0;
    imem_resp    = RESP_IDLE;
    mem_errors   = 0;
    stop         = 1'b0;
    wait_cnt     = 0;
    while (rst_n !== 1'b1 && wait_cnt < RST_TIMEOUT) begin
        @(negedge clk);
        wait_cnt++;
    end
    if (rst_n !== 1'b1) begin
        $display("ERROR at %0t: memory model saw no reset release", $time);
        mem_errors++;
        stop = 1'b1;
    end
    while (!stop) begin
        wait_cnt = 0;
        @(negedge clk);
        while (imem_req !== 1'b1 && wait_cnt < REQ_TIMEOUT) begin
            @(negedge clk);
            wait_cnt++;
        end
        if (imem_req !== 1'b1) begin
            $display("ERROR at %0t: no fetch request for %0d cycles", $time, REQ_TIMEOUT);
            mem_errors++;
            stop = 1'b1;
        end else begin
            word_idx = int'((imem_addr - `PIPE_RST_VECTOR) >> 2);
            delay    = $unsigned($random(seed)) % 3;
            repeat (delay) @(negedge clk);
            @(posedge clk);
            imem_req_ack <= 1'b1;
            @(posedge clk);
            imem_req_ack <= 1'b0;
            if (word_idx >= 0 && word_idx < N_ENTRIES) begin
                imem_rdata <= prog_instr[word_idx];
                imem_resp  <= prog_err[word_idx] ? RESP_ERR : RESP_OK;
            end else begin
                imem_rdata <= NOP;
                imem_resp  <= RESP_OK;
            end
            @(posedge clk);
            imem_resp <= RESP_IDLE;                // One cycle response
        end
    end
end

//--------------------------------------------------------------------
// End of run
//--------------------------------------------------------------------
initial begin : run_control
    int wait_cnt;
    int run_fail;
    wait_cnt = 0;
    run_fail = 0;
    while (chk_done !== 1'b1 && wait_cnt < RUN_TIMEOUT) begin
        @(posedge clk);
        wait_cnt++;
    end
    if (chk_done !== 1'b1) begin
        $display("ERROR at %0t: checker did not finish within %0d cycles", $time, RUN_TIMEOUT);
        run_fail = 1;
    end
    $display("Error count: %0d mismatches, %0d other failures",
             mismatch_cnt, other_cnt + mem_errors + run_fail);
    if (run_fail == 0 && mismatch_cnt == 0 && other_cnt + mem_errors == 0) begin
        $display("RESULT: PASS");
    end else begin
        $display("RESULT: FAIL");
    end
    $finish;
end

endmodule : tb_pipe_top

// File: all.f
+incdir+logic
logic/pipe_pkg.sv
logic/pipe_ifu.sv
logic/pipe_idu.sv
logic/pipe_exu.sv
logic/pipe_mprf.sv
logic/pipe_top.sv
tb/pipe_checker.sv
tb/tb_pipe_top.sv

// File: Makefile
VERILATOR := verilator
FLAGS     := --timing
TOP       := tb_pipe_top
RTL_TOP   := pipe_top
FILELIST  := all.f
OBJ_DIR   := obj_dir
PASS_TEXT := RESULT: PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(OBJ_DIR) -o V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
		echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
